/* source/madd_pkg.sv */
package madd_pkg;

	localparam int data_width = 16;
	localparam int result_width = 2 * data_width;

	localparam int n_lanes = 4;
	localparam int lane_index_width = 2;

	localparam int shift_width = 5;
	localparam int dest_width = 4;
	localparam int tag_width = 9;

	// clamp bounds of a data_width signed number, held at result width
	localparam logic signed [result_width-1:0] sat_max =
		result_width'((1 << (data_width - 1)) - 1);
	localparam logic signed [result_width-1:0] sat_min = ~sat_max;

	typedef enum logic [1:0] {
		op_mul  = 2'b00,	// shifted product only
		op_madd = 2'b01	// shifted product plus c
		// 2'b10 and 2'b11 reserved, decode as op_mul
	} madd_op;

endpackage

/* source/issue_dispatch.sv */
`timescale 1ns/100ps

module issue_dispatch
	import madd_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic enable,

	input  logic in_valid,
	output logic in_ready,

	output logic [n_lanes-1:0] lane_in_valid,
	input  logic [n_lanes-1:0] lane_in_ready
);

	logic [lane_index_width-1:0] issue_ptr;
	logic take_in;

	always_comb begin
		lane_in_valid = '0;
		lane_in_valid[issue_ptr] = in_valid;	// only the lane under the pointer
	end

	assign in_ready = lane_in_ready[issue_ptr];
	assign take_in = in_valid & in_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			issue_ptr <= '0;
		end else if (enable && take_in) begin
			if (issue_ptr == lane_index_width'(n_lanes - 1)) begin
				issue_ptr <= '0;
			end else begin
				issue_ptr <= issue_ptr + 1'b1;
			end
		end
	end

	a_one_lane_valid: assert property (
		@(posedge clk) disable iff (reset)
		$onehot0(lane_in_valid)
	) else $error("issue_dispatch: more than one lane_in_valid bit set");

	// a pending operation must wait for its lane, or issue order breaks
	a_in_valid_held: assert property (
		@(posedge clk) disable iff (reset)
		in_valid && !(in_ready && enable) |=> in_valid
	) else $error("issue_dispatch: in_valid dropped before transfer");

endmodule

/* source/madd_lane.sv */
`timescale 1ns/100ps

module madd_lane
	import madd_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic enable,

	input  logic in_valid,
	output logic in_ready,

	output logic out_valid,
	input  logic out_ready,

	input  madd_op op,
	input  logic [data_width-1:0] a,
	input  logic [data_width-1:0] b,
	input  logic [data_width-1:0] c,
	input  logic [shift_width-1:0] shift_amt,
	input  logic shift_disable,
	input  logic signedness,
	input  logic saturate_disable,
	input  logic [dest_width-1:0] dest,
	input  logic [tag_width-1:0] tag,

	output logic [result_width-1:0] result,
	output logic [dest_width-1:0] result_dest,
	output logic [tag_width-1:0] result_tag
);

	logic s1_valid, s2_valid, s3_valid;
	logic s1_ready, s2_ready, s3_ready, s4_ready;

	madd_op s1_op, s2_op;
	logic signed [result_width-1:0] s1_product;
	logic [data_width-1:0] s1_c, s2_c;
	logic [shift_width-1:0] s1_shift_amt;
	logic s1_shift_disable;
	logic s1_signedness, s2_signedness;
	logic s1_saturate_disable, s2_saturate_disable, s3_saturate_disable;
	logic [dest_width-1:0] s1_dest, s2_dest, s3_dest;
	logic [tag_width-1:0] s1_tag, s2_tag, s3_tag;
	logic signed [result_width-1:0] s2_value, s3_value;

	logic signed [result_width-1:0] product_s;
	logic [result_width-1:0] product_u;
	logic [shift_width-1:0] shift_cnt;
	logic [result_width-1:0] round_bias;
	logic signed [result_width-1:0] rounded;
	logic [result_width-1:0] c_ext;
	logic [result_width-1:0] addend;
	logic signed [result_width-1:0] clamped;

	// a stage takes new data when empty or when its output moves on
	assign s4_ready = ~out_valid | out_ready;
	assign s3_ready = ~s3_valid | s4_ready;
	assign s2_ready = ~s2_valid | s3_ready;
	assign s1_ready = ~s1_valid | s2_ready;
	assign in_ready = s1_ready;

	assign product_s = $signed(a) * $signed(b);
	assign product_u = a * b;

	assign shift_cnt = shift_width'(data_width - 1) - s1_shift_amt;
	assign round_bias = (shift_cnt == '0) ? '0 : (result_width'(1) << (shift_cnt - 1'b1));
	assign rounded = s1_product + round_bias;

	assign c_ext = s2_signedness ? {{data_width{s2_c[data_width-1]}}, s2_c}
		: {{data_width{1'b0}}, s2_c};
	assign addend = (s2_op == op_madd) ? c_ext : '0;	// reserved ops add nothing

	assign clamped = (s3_value > sat_max) ? sat_max
		: (s3_value < sat_min) ? sat_min : s3_value;

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			s3_valid <= 1'b0;
			out_valid <= 1'b0;
		end else if (enable) begin
			if (s1_ready) s1_valid <= in_valid;
			if (s2_ready) s2_valid <= s1_valid;
			if (s3_ready) s3_valid <= s2_valid;
			if (s4_ready) out_valid <= s3_valid;
		end
	end

	// multiply
	always_ff @(posedge clk) begin
		if (enable && in_valid && s1_ready) begin
			s1_op <= op;
			s1_product <= signedness ? product_s : product_u;
			s1_c <= c;
			s1_shift_amt <= shift_amt;
			s1_shift_disable <= shift_disable;
			s1_signedness <= signedness;
			s1_saturate_disable <= saturate_disable;
			s1_dest <= dest;
			s1_tag <= tag;
		end
	end

	// round and shift down to fixed point
	always_ff @(posedge clk) begin
		if (enable && s1_valid && s2_ready) begin
			s2_op <= s1_op;
			s2_value <= s1_shift_disable ? s1_product : (rounded >>> shift_cnt);
			s2_c <= s1_c;
			s2_signedness <= s1_signedness;
			s2_saturate_disable <= s1_saturate_disable;
			s2_dest <= s1_dest;
			s2_tag <= s1_tag;
		end
	end

	// accumulate
	always_ff @(posedge clk) begin
		if (enable && s2_valid && s3_ready) begin
			s3_value <= s2_value + addend;
			s3_saturate_disable <= s2_saturate_disable;
			s3_dest <= s2_dest;
			s3_tag <= s2_tag;
		end
	end

	// saturate
	always_ff @(posedge clk) begin
		if (enable && s3_valid && s4_ready) begin
			result <= s3_saturate_disable ? s3_value : clamped;
			result_dest <= s3_dest;
			result_tag <= s3_tag;
		end
	end

	a_out_stable: assert property (
		@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=>
			out_valid && $stable(result) && $stable(result_dest) && $stable(result_tag)
	) else $error("madd_lane: output changed while stalled");

endmodule

/* source/result_collector.sv */
`timescale 1ns/100ps

module result_collector
	import madd_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic enable,

	input  logic [n_lanes-1:0] lane_out_valid,
	output logic [n_lanes-1:0] lane_out_ready,
	input  logic [result_width-1:0] lane_result [n_lanes],
	input  logic [dest_width-1:0] lane_dest [n_lanes],
	input  logic [tag_width-1:0] lane_tag [n_lanes],

	output logic out_valid,
	input  logic out_ready,
	output logic [result_width-1:0] result,
	output logic [dest_width-1:0] result_dest,
	output logic [tag_width-1:0] result_tag
);

	logic [lane_index_width-1:0] retire_ptr;
	logic take_out;

	// head lane only, so results leave in issue order
	assign out_valid = lane_out_valid[retire_ptr];
	assign result = lane_result[retire_ptr];
	assign result_dest = lane_dest[retire_ptr];
	assign result_tag = lane_tag[retire_ptr];

	always_comb begin
		lane_out_ready = '0;
		lane_out_ready[retire_ptr] = out_ready;
	end

	assign take_out = out_valid & out_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			retire_ptr <= '0;
		end else if (enable && take_out) begin
			if (retire_ptr == lane_index_width'(n_lanes - 1)) begin
				retire_ptr <= '0;
			end else begin
				retire_ptr <= retire_ptr + 1'b1;
			end
		end
	end

	a_one_lane_ready: assert property (
		@(posedge clk) disable iff (reset)
		$onehot0(lane_out_ready)
	) else $error("result_collector: more than one lane_out_ready bit set");

	// head result must not move or vanish until it is taken
	a_head_held: assert property (
		@(posedge clk) disable iff (reset)
		out_valid && !(out_ready && enable) |=>
			out_valid && $stable(result_tag) && $stable(result)
	) else $error("result_collector: head result lost before transfer");

endmodule

/* source/madd_cluster.sv */
`timescale 1ns/100ps

module madd_cluster
	import madd_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic enable,

	input  logic in_valid,
	output logic in_ready,
	input  madd_op op,
	input  logic [data_width-1:0] a,
	input  logic [data_width-1:0] b,
	input  logic [data_width-1:0] c,
	input  logic [shift_width-1:0] shift_amt,
	input  logic shift_disable,
	input  logic signedness,
	input  logic saturate_disable,
	input  logic [dest_width-1:0] dest,
	input  logic [tag_width-1:0] tag,

	output logic out_valid,
	input  logic out_ready,
	output logic [result_width-1:0] result,
	output logic [dest_width-1:0] result_dest,
	output logic [tag_width-1:0] result_tag
);

	logic [n_lanes-1:0] lane_in_valid;
	logic [n_lanes-1:0] lane_in_ready;
	logic [n_lanes-1:0] lane_out_valid;
	logic [n_lanes-1:0] lane_out_ready;
	logic [result_width-1:0] lane_result [n_lanes];
	logic [dest_width-1:0] lane_dest [n_lanes];
	logic [tag_width-1:0] lane_tag [n_lanes];

	issue_dispatch u_issue_dispatch (
		.clk(clk),
		.reset(reset),
		.enable(enable),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.lane_in_valid(lane_in_valid),
		.lane_in_ready(lane_in_ready)
	);

	// operation fields fan out to every lane, valid picks one
	for (genvar i = 0; i < n_lanes; i++) begin : g_lane
		madd_lane u_madd_lane (
			.clk(clk),
			.reset(reset),
			.enable(enable),
			.in_valid(lane_in_valid[i]),
			.in_ready(lane_in_ready[i]),
			.out_valid(lane_out_valid[i]),
			.out_ready(lane_out_ready[i]),
			.op(op),
			.a(a),
			.b(b),
			.c(c),
			.shift_amt(shift_amt),
			.shift_disable(shift_disable),
			.signedness(signedness),
			.saturate_disable(saturate_disable),
			.dest(dest),
			.tag(tag),
			.result(lane_result[i]),
			.result_dest(lane_dest[i]),
			.result_tag(lane_tag[i])
		);
	end

	result_collector u_result_collector (
		.clk(clk),
		.reset(reset),
		.enable(enable),
		.lane_out_valid(lane_out_valid),
		.lane_out_ready(lane_out_ready),
		.lane_result(lane_result),
		.lane_dest(lane_dest),
		.lane_tag(lane_tag),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.result(result),
		.result_dest(result_dest),
		.result_tag(result_tag)
	);

endmodule

/* tests/clock_gen.sv */
`timescale 1ns/100ps

module clock_gen (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;	// 4 ns period
	end

endmodule

/* tests/tb_madd_cluster.sv */
`timescale 1ns/100ps

module tb_madd_cluster
	import madd_pkg::*;
();

	typedef enum {mix_signed, near_full_unsigned, mix_any} stim_kind;
	typedef enum {ready_high, ready_duty30, ready_low} ready_kind;

	logic clk, reset, enable;
	logic in_valid, in_ready;
	madd_op op;
	logic [data_width-1:0] a, b, c;
	logic [shift_width-1:0] shift_amt;
	logic shift_disable, signedness, saturate_disable;
	logic [dest_width-1:0] dest;
	logic [tag_width-1:0] tag;
	logic out_valid, out_ready;
	logic [result_width-1:0] result;
	logic [dest_width-1:0] result_dest;
	logic [tag_width-1:0] result_tag;

	logic [31:0] rng_state;
	logic [tag_width-1:0] next_tag;
	ready_kind ready_mode;
	logic [result_width-1:0] exp_result_q[$];
	logic [dest_width-1:0] exp_dest_q[$];
	logic [tag_width-1:0] exp_tag_q[$];
	int error_count, check_count, tests_run, tests_failed, test_errors_start;
	int in_count, out_count, stall_cycles;

	clock_gen u_clock_gen (.clk(clk));

	madd_cluster u_madd_cluster (.*);

	function automatic logic [31:0] xorshift32(input logic [31:0] state);
		logic [31:0] s;
		s = state;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic logic [31:0] rand_word();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// reference model, worked out in 64-bit and wrapped to the 32-bit result
	function automatic logic [result_width-1:0] expected_result(
		input madd_op op_in,
		input logic [data_width-1:0] a_in,
		input logic [data_width-1:0] b_in,
		input logic [data_width-1:0] c_in,
		input logic [shift_width-1:0] amt,
		input logic no_shift,
		input logic is_signed,
		input logic no_sat
	);
		longint value;
		longint addend;
		longint hi;
		longint lo;
		int k;
		hi = (longint'(1) << (data_width - 1)) - 1;
		lo = -hi - 1;
		if (is_signed) begin
			value = longint'($signed(a_in)) * longint'($signed(b_in));
		end else begin
			value = longint'(a_in) * longint'(b_in);
		end
		value = longint'($signed(value[result_width-1:0]));	// product as a signed word
		if (!no_shift) begin
			k = data_width - 1 - int'(amt);
			if (k > 0) value = value + (longint'(1) << (k - 1));	// half the divisor
			value = longint'($signed(value[result_width-1:0])) >>> k;
		end
		if (op_in == op_madd) begin
			addend = is_signed ? longint'($signed(c_in)) : longint'(c_in);
		end else begin
			addend = 0;	// op_mul and reserved codes
		end
		value = longint'($signed(value[result_width-1:0])) + addend;
		value = longint'($signed(value[result_width-1:0]));
		if (!no_sat) begin
			if (value > hi) value = hi;
			else if (value < lo) value = lo;
		end
		return value[result_width-1:0];
	endfunction

	task automatic count_wait(ref int waited, input string what);
		waited++;
		if (waited > 400) begin
			$display("timeout after %0d cycles waiting for %s", waited, what);
			$display("Checks failed");
			$finish;
		end
	endtask

	task automatic drive_out_ready();
		logic [31:0] r;
		case (ready_mode)
			ready_high: out_ready = 1'b1;
			ready_duty30: begin
				r = rand_word();
				out_ready = (r % 10) < 3;
			end
			default: out_ready = 1'b0;
		endcase
	endtask

	task automatic load_op(input stim_kind kind);
		logic [31:0] r1, r2, r3;
		r1 = rand_word();
		r2 = rand_word();
		r3 = rand_word();
		a = r1[15:0];
		b = r1[31:16];
		c = r2[15:0];
		shift_amt = {1'b0, r2[19:16]};	// 0 to 15
		shift_disable = r2[20];
		dest = r2[24:21];
		op = r2[25] ? op_madd : op_mul;
		saturate_disable = r2[26];
		signedness = 1'b1;
		if (kind == near_full_unsigned) begin
			signedness = 1'b0;
			saturate_disable = r3[0];
			a = ~{8'h00, r1[7:0]};
			b = ~{8'h00, r1[23:16]};
			c = ~{8'h00, r2[7:0]};
		end else if (kind == mix_any) begin
			signedness = r3[0];
			op = madd_op'(r3[2:1]);	// reserved codes too
		end
		tag = next_tag;
		next_tag++;
		in_valid = 1'b1;
	endtask

	// hold the loaded op until an edge takes it, leaves at a falling edge
	task automatic send_loaded_op();
		int waited;
		logic taken;
		waited = 0;
		taken = 1'b0;
		while (!taken) begin
			@(posedge clk);
			taken = in_valid && in_ready && enable;
			@(negedge clk);
			drive_out_ready();
			if (!taken) begin
				stall_cycles++;
				count_wait(waited, "input acceptance");
			end
		end
		in_valid = 1'b0;
	endtask

	task automatic issue_ops(input int count, input stim_kind kind);
		for (int i = 0; i < count; i++) begin
			load_op(kind);
			send_loaded_op();
		end
	endtask

	task automatic drain_results();
		int waited;
		waited = 0;
		while (exp_tag_q.size() != 0) begin
			@(posedge clk);
			@(negedge clk);
			drive_out_ready();
			count_wait(waited, "results to drain");
		end
	endtask

	task automatic check_idle();
		if (out_valid !== 1'b0) begin
			error_count++;
			$display("ERROR %0t: out_valid still high with no result pending", $time);
		end
		if (in_count != out_count) begin
			error_count++;
			$display("ERROR %0t: %0d issued but %0d retired", $time, in_count, out_count);
		end
	endtask

	task automatic compare_output();
		logic [result_width-1:0] want_result;
		logic [dest_width-1:0] want_dest;
		logic [tag_width-1:0] want_tag;
		check_count++;
		out_count++;
		if (exp_tag_q.size() == 0) begin
			error_count++;
			$display("ERROR %0t: tag %0d retired with nothing pending", $time, result_tag);
		end else begin
			want_result = exp_result_q.pop_front();
			want_dest = exp_dest_q.pop_front();
			want_tag = exp_tag_q.pop_front();
			if (result_tag !== want_tag) begin
				error_count++;
				$display("ERROR %0t: tag %0d, expected %0d", $time, result_tag, want_tag);
			end
			if (result !== want_result) begin
				error_count++;
				$display("ERROR %0t: tag %0d result %h, expected %h", $time, want_tag,
					result, want_result);
			end
			if (result_dest !== want_dest) begin
				error_count++;
				$display("ERROR %0t: tag %0d dest %0d, expected %0d", $time, want_tag,
					result_dest, want_dest);
			end
		end
	endtask

	// scoreboard, sees both handshakes at the rising edge
	always @(posedge clk) begin
		if (!reset && enable) begin
			if (in_valid && in_ready) begin
				exp_result_q.push_back(expected_result(op, a, b, c, shift_amt,
					shift_disable, signedness, saturate_disable));
				exp_dest_q.push_back(dest);
				exp_tag_q.push_back(tag);
				in_count++;
			end
			if (out_valid && out_ready) compare_output();
		end
	end

	task automatic begin_test();
		tests_run++;
		test_errors_start = error_count;
	endtask

	task automatic end_test(input string name);
		int errs;
		errs = error_count - test_errors_start;
		if (errs != 0) tests_failed++;
		$display("test %0d %s: %s, %0d errors", tests_run, name,
			(errs == 0) ? "ok" : "FAILED", errs);
	endtask

	task automatic enable_hold_test();
		logic snap_valid, snap_ready;
		logic [result_width-1:0] snap_result;
		logic [tag_width-1:0] snap_tag;
		ready_mode = ready_low;
		drive_out_ready();
		issue_ops(8, mix_any);	// results pile up behind out_ready
		enable = 1'b0;
		load_op(mix_any);
		ready_mode = ready_high;
		drive_out_ready();
		@(posedge clk);
		@(negedge clk);
		snap_valid = out_valid;
		snap_ready = in_ready;
		snap_result = result;
		snap_tag = result_tag;
		// both sides offer a transfer, so only enable keeps them from counting
		check_count++;
		if (snap_valid !== 1'b1 || snap_ready !== 1'b1) begin
			error_count++;
			$display("ERROR %0t: enable low, out_valid %b in_ready %b, expected both high",
				$time, snap_valid, snap_ready);
		end
		for (int i = 0; i < 20; i++) begin
			@(posedge clk);
			@(negedge clk);
			check_count++;
			if (out_valid !== snap_valid || in_ready !== snap_ready ||
				result !== snap_result || result_tag !== snap_tag) begin
				error_count++;
				$display("ERROR %0t: cluster state moved while enable was low", $time);
			end
		end
		enable = 1'b1;
		send_loaded_op();
		drain_results();
		check_idle();
	endtask

	initial begin
		rng_state = 32'hc87e1ce4;
		reset = 1'b1;
		enable = 1'b1;
		in_valid = 1'b0;
		op = op_mul;
		a = '0;
		b = '0;
		c = '0;
		shift_amt = '0;
		shift_disable = 1'b0;
		signedness = 1'b0;
		saturate_disable = 1'b0;
		dest = '0;
		tag = '0;
		out_ready = 1'b0;
		ready_mode = ready_high;
		next_tag = '0;
		error_count = 0;
		check_count = 0;
		tests_run = 0;
		tests_failed = 0;
		in_count = 0;
		out_count = 0;
		stall_cycles = 0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		begin_test();
		check_count++;
		if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
			error_count++;
			$display("ERROR %0t: after reset out_valid %b in_ready %b", $time,
				out_valid, in_ready);
		end
		end_test("reset state");

		begin_test();
		ready_mode = ready_high;
		drive_out_ready();
		issue_ops(300, mix_signed);
		drain_results();
		check_idle();
		end_test("signed mul and madd");

		begin_test();
		issue_ops(300, near_full_unsigned);
		drain_results();
		check_idle();
		end_test("unsigned near full scale");

		begin_test();
		stall_cycles = 0;
		ready_mode = ready_duty30;
		issue_ops(300, mix_any);
		drain_results();
		check_idle();
		if (stall_cycles == 0) begin
			error_count++;
			$display("the input side never stalled under back-pressure");
		end
		end_test("back-pressure at 30 percent");

		begin_test();
		enable_hold_test();
		end_test("enable held low");

		$display("%0d tests, %0d failed, %0d checks, %0d errors", tests_run,
			tests_failed, check_count, error_count);
		if (error_count == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

/* files.f */
source/madd_pkg.sv
source/issue_dispatch.sv
source/madd_lane.sv
source/result_collector.sv
source/madd_cluster.sv
tests/clock_gen.sv
tests/tb_madd_cluster.sv

/* Makefile */
# Verilator build and run for the multiply-accumulate cluster testbench
VERILATOR ?= verilator
TOP ?= tb_madd_cluster
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) \
		-o $(TOP) -f $(FILE_LIST)

# status comes from grep, so a missing pass line fails the target
run: compile
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
